// File: bench/tb_xt_chipset.sv
// Testbench for the XT peripheral bus glue
// Runs a table of bus, keyboard and timer operations through the top level
// and compares each response with the expected value

`default_nettype none

module tb_xt_chipset;
    import xt_bus_pkg::*;

    typedef enum int {
        OP_IDLE,
        OP_WRITE,
        OP_READ,
        OP_PROBE,
        OP_PROBE_IO,
        OP_KEY,
        OP_PORTB,
        OP_TIMER
    } op_t;

    // Where a read takes its expected byte from
    localparam int SRC_TABLE = 0;
    localparam int SRC_PIC   = 1;
    localparam int SRC_PIT   = 2;
    localparam int SRC_PPI   = 3;
    localparam int MAX_TESTS = 32;

    logic       clock;
    logic       reset;
    addr_t      address_i;
    byte_t      data_i;
    logic       io_read_n_i;
    logic       io_write_n_i;
    logic       memory_read_n_i;
    logic       address_enable_n_i;
    logic       inta_n_i;
    byte_t      pic_data_i;
    byte_t      pit_data_i;
    byte_t      ppi_data_i;
    logic       peripheral_clock_i;
    logic       kbd_irq_i;
    byte_t      keycode_i;
    byte_t      port_b_i;
    logic       ems_enabled_i;
    logic [1:0] ems_frame_i;
    logic       dma_cs_n_o;
    logic       pic_cs_n_o;
    logic       pit_cs_n_o;
    logic       ppi_cs_n_o;
    logic       dma_page_cs_n_o;
    byte_t      data_bus_o;
    logic       from_chipset_o;
    logic [3:0] ems_hit_o;
    logic       timer_clock_o;
    byte_t      port_a_o;
    logic       irq_o;
    logic       kbd_reset_req_o;
    logic       ps2_clock_o;

    // Test table, one column per array
    string      t_name   [MAX_TESTS];
    op_t        t_op     [MAX_TESTS];
    addr_t      t_addr   [MAX_TESTS];
    byte_t      t_data   [MAX_TESTS];
    logic [8:0] t_exp    [MAX_TESTS];
    logic [4:0] t_cs     [MAX_TESTS];
    logic       t_ems_en [MAX_TESTS];
    int         t_src    [MAX_TESTS];

    int    num_tests;
    logic  table_ready;
    int    test_errors;
    int    pass_count;
    int    fail_count;
    int    cycle_count;
    int    cycle_limit;
    int    seed_value;
    byte_t last_keycode;

    xt_chipset_top i_dut (
        .clock              (clock),
        .reset              (reset),
        .address_i          (address_i),
        .data_i             (data_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .memory_read_n_i    (memory_read_n_i),
        .address_enable_n_i (address_enable_n_i),
        .inta_n_i           (inta_n_i),
        .pic_data_i         (pic_data_i),
        .pit_data_i         (pit_data_i),
        .ppi_data_i         (ppi_data_i),
        .dma_cs_n_o         (dma_cs_n_o),
        .pic_cs_n_o         (pic_cs_n_o),
        .pit_cs_n_o         (pit_cs_n_o),
        .ppi_cs_n_o         (ppi_cs_n_o),
        .dma_page_cs_n_o    (dma_page_cs_n_o),
        .peripheral_clock_i (peripheral_clock_i),
        .timer_clock_o      (timer_clock_o),
        .kbd_irq_i          (kbd_irq_i),
        .keycode_i          (keycode_i),
        .port_b_i           (port_b_i),
        .port_a_o           (port_a_o),
        .irq_o              (irq_o),
        .kbd_reset_req_o    (kbd_reset_req_o),
        .ps2_clock_o        (ps2_clock_o),
        .ems_enabled_i      (ems_enabled_i),
        .ems_frame_i        (ems_frame_i),
        .ems_hit_o          (ems_hit_o),
        .data_bus_o         (data_bus_o),
        .from_chipset_o     (from_chipset_o)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic add_test(input string name, input op_t op, input addr_t addr,
                            input byte_t data, input logic [8:0] exp,
                            input logic [4:0] cs, input logic ems_en, input int src);
        t_name[num_tests]   = name;
        t_op[num_tests]     = op;
        t_addr[num_tests]   = addr;
        t_data[num_tests]   = data;
        t_exp[num_tests]    = exp;
        t_cs[num_tests]     = cs;
        t_ems_en[num_tests] = ems_en;
        t_src[num_tests]    = src;
        num_tests++;
    endtask

    task automatic release_bus();
        address_i          = '0;
        data_i             = '0;
        io_read_n_i        = 1'b1;
        io_write_n_i       = 1'b1;
        memory_read_n_i    = 1'b1;
        address_enable_n_i = 1'b1;
    endtask

    task automatic write_io(input int idx);
        address_i          = t_addr[idx];
        data_i             = t_data[idx];
        io_write_n_i       = 1'b0;
        address_enable_n_i = 1'b0;
        @(negedge clock);
        release_bus();
        // EMS slot commits on the second edge
        @(negedge clock);
    endtask

    task automatic read_io(input int idx);
        logic [4:0] cs_active;
        logic [8:0] expected;
        address_i          = t_addr[idx];
        io_read_n_i        = 1'b0;
        address_enable_n_i = 1'b0;
        @(negedge clock);
        cs_active = {~dma_page_cs_n_o, ~ppi_cs_n_o, ~pit_cs_n_o, ~pic_cs_n_o, ~dma_cs_n_o};
        case (t_src[idx])
            SRC_PIC: expected = {1'b1, pic_data_i};
            SRC_PIT: expected = {1'b1, pit_data_i};
            SRC_PPI: expected = {1'b1, ppi_data_i};
            default: expected = t_exp[idx];
        endcase
        check({t_name[idx], " select"}, 16'(t_cs[idx]), 16'(cs_active));
        check({t_name[idx], " data"}, 16'(expected), 16'({from_chipset_o, data_bus_o}));
        release_bus();
    endtask

    task automatic probe_frame(input int idx, input logic with_io);
        address_i          = t_addr[idx];
        memory_read_n_i    = with_io;
        io_read_n_i        = ~with_io;
        address_enable_n_i = 1'b0;
        @(negedge clock);
        check(t_name[idx], 16'(t_exp[idx]), 16'(ems_hit_o));
        release_bus();
    endtask

    // Keycode arrives together with the keyboard interrupt
    task automatic send_keycode(input int idx);
        keycode_i = t_data[idx];
        kbd_irq_i = 1'b1;
        @(negedge clock);
        check({t_name[idx], " after one clock"}, 16'(last_keycode), 16'(port_a_o));
        check({t_name[idx], " irq after one clock"}, 16'h0000, 16'(irq_o));
        @(negedge clock);
        check({t_name[idx], " after two clocks"}, 16'(t_exp[idx]), 16'(port_a_o));
        check({t_name[idx], " irq after two clocks"}, 16'h0001, 16'(irq_o));
        check({t_name[idx], " irq inhibit"}, 16'h0000, 16'(ps2_clock_o));
        kbd_irq_i    = 1'b0;
        last_keycode = t_data[idx];
    endtask

    task automatic toggle_port_b(input int idx);
        int pulses;
        pulses   = 0;
        port_b_i = 8'h00;
        repeat (3) @(negedge clock);
        check({t_name[idx], " inhibit"}, 16'h0000, 16'(ps2_clock_o));
        port_b_i = t_data[idx];
        repeat (6) begin
            @(negedge clock);
            if (kbd_reset_req_o) begin
                pulses++;
            end
        end
        check({t_name[idx], " pulses"}, 16'(t_exp[idx]), 16'(pulses));
        check({t_name[idx], " release"}, 16'h0001, 16'(ps2_clock_o));
    endtask

    // Peripheral clock period is four bus clocks, then a flush for the synchronizer
    task automatic count_timer_toggles(input int idx);
        int   toggles;
        int   steps;
        logic last_level;
        toggles    = 0;
        steps      = int'(t_data[idx]) * 4;
        last_level = timer_clock_o;
        for (int i = 0; i < steps + 6; i++) begin
            peripheral_clock_i = (i < steps) && ((i % 4) < 2);
            @(negedge clock);
            if (timer_clock_o !== last_level) begin
                toggles++;
            end
            last_level = timer_clock_o;
        end
        check(t_name[idx], 16'(t_exp[idx]), 16'(toggles));
    endtask

    // Status packed as from_chipset, irq, reset request, hits, ps2 clock, timer clock
    task automatic compare_status(input int idx);
        check(t_name[idx], 16'(t_exp[idx]),
              16'({from_chipset_o, irq_o, kbd_reset_req_o, ems_hit_o, ps2_clock_o,
                   timer_clock_o}));
    endtask

    task automatic build_table();
        num_tests = 0;
        add_test("reset state", OP_IDLE, 20'h00000, 8'h00, 9'h002, 5'b00000, 1'b1, SRC_TABLE);
        add_test("pic read", OP_READ, 20'h00020, 8'h00, 9'h000, 5'b00010, 1'b1, SRC_PIC);
        add_test("pit read", OP_READ, 20'h00040, 8'h00, 9'h000, 5'b00100, 1'b1, SRC_PIT);
        add_test("ppi read", OP_READ, 20'h00060, 8'h00, 9'h000, 5'b01000, 1'b1, SRC_PPI);
        add_test("unmapped read", OP_READ, 20'h00300, 8'h00, 9'h000, 5'b00000, 1'b1, SRC_TABLE);
        add_test("lpt idle read", OP_READ, 20'h00378, 8'h00, 9'h1FF, 5'b00000, 1'b1, SRC_TABLE);
        add_test("lpt write", OP_WRITE, 20'h00378, 8'hA5, 9'h000, 5'b00000, 1'b1, SRC_TABLE);
        add_test("lpt read", OP_READ, 20'h00378, 8'h00, 9'h1A5, 5'b00000, 1'b1, SRC_TABLE);
        add_test("ems map write", OP_WRITE, 20'h00261, 8'h05, 9'h000, 5'b00000, 1'b1, SRC_TABLE);
        add_test("ems map read", OP_READ, 20'h00261, 8'h00, 9'h105, 5'b00000, 1'b1, SRC_TABLE);
        add_test("ems bad write", OP_WRITE, 20'h00261, 8'h90, 9'h000, 5'b00000, 1'b1, SRC_TABLE);
        add_test("ems kept read", OP_READ, 20'h00261, 8'h00, 9'h105, 5'b00000, 1'b1, SRC_TABLE);
        add_test("ems unmap write", OP_WRITE, 20'h00261, 8'hFF, 9'h000, 5'b00000, 1'b1, SRC_TABLE);
        add_test("ems unmap read", OP_READ, 20'h00261, 8'h00, 9'h1FF, 5'b00000, 1'b1, SRC_TABLE);
        add_test("ems off write", OP_WRITE, 20'h00261, 8'h22, 9'h000, 5'b00000, 1'b0, SRC_TABLE);
        add_test("ems off read", OP_READ, 20'h00261, 8'h00, 9'h000, 5'b00000, 1'b0, SRC_TABLE);
        add_test("ems on read", OP_READ, 20'h00261, 8'h00, 9'h1FF, 5'b00000, 1'b1, SRC_TABLE);
        add_test("ems slot 1 map", OP_WRITE, 20'h00261, 8'h12, 9'h000, 5'b00000, 1'b1, SRC_TABLE);
        add_test("probe slot 1", OP_PROBE, 20'hC4000, 8'h00, 9'h002, 5'b00000, 1'b1, SRC_TABLE);
        add_test("probe slot 0", OP_PROBE, 20'hC0000, 8'h00, 9'h000, 5'b00000, 1'b1, SRC_TABLE);
        add_test("probe in io", OP_PROBE_IO, 20'hC4000, 8'h00, 9'h000, 5'b00000, 1'b1, SRC_TABLE);
        add_test("keycode 3Ch", OP_KEY, 20'h00000, 8'h3C, 9'h03C, 5'b00000, 1'b1, SRC_TABLE);
        add_test("keycode 9Ah", OP_KEY, 20'h00000, 8'h9A, 9'h09A, 5'b00000, 1'b1, SRC_TABLE);
        add_test("port b rise", OP_PORTB, 20'h00000, 8'h40, 9'h001, 5'b00000, 1'b1, SRC_TABLE);
        add_test("timer clock", OP_TIMER, 20'h00000, 8'd40, 9'd40, 5'b00000, 1'b1, SRC_TABLE);
    endtask

    // Watchdog
    initial begin
        cycle_count = 0;
        wait (table_ready);
        cycle_limit = num_tests * 10 + 200;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        table_ready        = 1'b0;
        seed_value         = $urandom(51);
        reset              = 1'b1;
        inta_n_i           = 1'b1;
        pic_data_i         = '0;
        pit_data_i         = '0;
        ppi_data_i         = '0;
        peripheral_clock_i = 1'b0;
        kbd_irq_i          = 1'b0;
        keycode_i          = '0;
        port_b_i           = 8'h40;
        ems_enabled_i      = 1'b1;
        ems_frame_i        = 2'd1;
        last_keycode       = '0;
        pass_count         = 0;
        fail_count         = 0;
        release_bus();
        build_table();
        table_ready = 1'b1;

        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int idx = 0; idx < num_tests; idx++) begin
            @(negedge clock);
            test_errors   = 0;
            pic_data_i    = byte_t'($urandom);
            pit_data_i    = byte_t'($urandom);
            ppi_data_i    = byte_t'($urandom);
            ems_enabled_i = t_ems_en[idx];
            case (t_op[idx])
                OP_WRITE:    write_io(idx);
                OP_READ:     read_io(idx);
                OP_PROBE:    probe_frame(idx, 1'b0);
                OP_PROBE_IO: probe_frame(idx, 1'b1);
                OP_KEY:      send_keycode(idx);
                OP_PORTB:    toggle_port_b(idx);
                OP_TIMER:    count_timer_toggles(idx);
                default:     compare_status(idx);
            endcase
            if (test_errors == 0) begin
                pass_count++;
                $display("ok    %s", t_name[idx]);
            end else begin
                fail_count++;
                $display("fail  %s", t_name[idx]);
            end
        end

        $display("Tests: %0d run, %0d passed, %0d failed", num_tests, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/bus_read_mux.sv
// Chipset read-back multiplexer
// Parallel-port data latch and the registered priority selection of
// the byte returned to the CPU

`default_nettype none

module bus_read_mux (
    input  logic              clock,
    input  logic              reset,
    input  xt_bus_pkg::byte_t data_i,
    input  logic              io_read_n_i,
    input  logic              io_write_n_i,
    input  logic              inta_n_i,
    input  logic              pic_cs_n_i,
    input  logic              pit_cs_n_i,
    input  logic              ppi_cs_n_i,
    input  logic              ems_sel_i,
    input  logic              lpt_sel_i,
    input  xt_bus_pkg::byte_t pic_data_i,
    input  xt_bus_pkg::byte_t pit_data_i,
    input  xt_bus_pkg::byte_t ppi_data_i,
    input  xt_bus_pkg::byte_t ems_data_i,
    output xt_bus_pkg::byte_t data_bus_o,
    output logic              from_chipset_o
);
    import xt_bus_pkg::*;

    byte_t lpt_data;
    logic  io_read;

    assign io_read = ~io_read_n_i;

    // Parallel port data register, idles high like a floating port
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data <= 8'hFF;
        end else if (lpt_sel_i && !io_write_n_i) begin
            lpt_data <= data_i;
        end
    end

    // Interrupt vector first, then the device reads in fixed order
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            from_chipset_o <= 1'b0;
            data_bus_o     <= '0;
        end else if (!inta_n_i) begin
            from_chipset_o <= 1'b1;
            data_bus_o     <= pic_data_i;
        end else if (!pic_cs_n_i && io_read) begin
            from_chipset_o <= 1'b1;
            data_bus_o     <= pic_data_i;
        end else if (!pit_cs_n_i && io_read) begin
            from_chipset_o <= 1'b1;
            data_bus_o     <= pit_data_i;
        end else if (!ppi_cs_n_i && io_read) begin
            from_chipset_o <= 1'b1;
            data_bus_o     <= ppi_data_i;
        end else if (ems_sel_i && io_read) begin
            from_chipset_o <= 1'b1;
            data_bus_o     <= ems_data_i;
        end else if (lpt_sel_i && io_read) begin
            from_chipset_o <= 1'b1;
            data_bus_o     <= lpt_data;
        end else begin
            from_chipset_o <= 1'b0;
            data_bus_o     <= '0;
        end
    end

    // Bus merge upstream ORs the chipset byte in
    a_idle_zero : assert property (@(posedge clock) disable iff (reset)
        !from_chipset_o |-> data_bus_o == '0)
        else $error("bus_read_mux: data driven without from_chipset");

endmodule

`default_nettype wire

// File: src/ems_mapper.sv
// EMS page mapper
// Four page registers written through ports 260h to 263h, with the
// page-frame hit detection for memory cycles

`default_nettype none

module ems_mapper (
    input  logic                  clock,
    input  logic                  reset,
    input  xt_bus_pkg::addr_t     address_i,
    input  xt_bus_pkg::byte_t     data_i,
    input  logic                  io_write_n_i,
    input  logic                  ems_sel_i,
    input  logic                  io_cycle_i,
    input  logic [1:0]            ems_frame_i,
    output logic [3:0]            ems_hit_o,
    output xt_bus_pkg::byte_t     read_byte_o
);
    import xt_bus_pkg::*;

    ems_wr_state_t state;
    logic          ems_write;
    logic          ems_write_q;
    logic          write_start;
    ems_slot_t     commit_slot;
    byte_t         commit_data;
    logic          commit_disable;
    logic          commit_map;
    ems_map_t      page [4];
    logic [3:0]    page_enable;
    ems_slot_t     read_slot;
    logic [3:0]    frame_nibble;

    assign ems_write   = ems_sel_i & ~io_write_n_i;
    // Only the first clock of a long write strobe counts
    assign write_start = ems_write & ~ems_write_q & (state == EMS_IDLE);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state       <= EMS_IDLE;
            ems_write_q <= 1'b0;
        end else begin
            ems_write_q <= ems_write;
            case (state)
                EMS_IDLE: begin
                    if (write_start) begin
                        state <= EMS_COMMIT;
                    end
                end
                default: state <= EMS_IDLE;
            endcase
        end
    end

    // Slot and byte held for the commit step
    always_ff @(posedge clock) begin
        if (write_start) begin
            commit_slot <= address_i[1:0];
            commit_data <= data_i;
        end
    end

    // FFh unmaps the slot, anything from 80h up is ignored
    assign commit_disable = (commit_data == EMS_DISABLE_CODE);
    assign commit_map     = (commit_data < EMS_MAP_LIMIT);

    always_ff @(posedge clock) begin
        if (state == EMS_COMMIT) begin
            if (commit_disable) begin
                page[commit_slot] <= 7'h7F;
            end else if (commit_map) begin
                page[commit_slot] <= commit_data[6:0];
            end
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            page_enable <= '0;
        end else if (state == EMS_COMMIT) begin
            if (commit_disable) begin
                page_enable[commit_slot] <= 1'b0;
            end else if (commit_map) begin
                page_enable[commit_slot] <= 1'b1;
            end
        end
    end

    // Register read-back
    assign read_slot   = address_i[1:0];
    assign read_byte_o = page_enable[read_slot] ? {1'b0, page[read_slot]} : IDLE_BYTE;

    always_comb begin
        case (ems_frame_i)
            2'd0:    frame_nibble = EMS_FRAME_A;
            2'd1:    frame_nibble = EMS_FRAME_C;
            default: frame_nibble = EMS_FRAME_D;
        endcase
    end

    // Each slot covers one 16 KB window of the 64 KB frame
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            ems_hit_o[n] = ~io_cycle_i & page_enable[n]
                         & (address_i[19:14] == {frame_nibble, ems_slot_t'(n)});
        end
    end

    a_commit_single : assert property (@(posedge clock) disable iff (reset)
        state == EMS_COMMIT |=> state == EMS_IDLE)
        else $error("ems_mapper: EMS_COMMIT held for two cycles");

endmodule

`default_nettype wire

// File: src/io_decoder.sv
// I/O address decoder
// Turns the CPU address and bus strobes into the low-port chip selects
// and the EMS and parallel-port selects

`default_nettype none

module io_decoder (
    input  xt_bus_pkg::addr_t address_i,
    input  logic              io_read_n_i,
    input  logic              io_write_n_i,
    input  logic              address_enable_n_i,
    input  logic              ems_enabled_i,
    output logic              dma_cs_n_o,
    output logic              pic_cs_n_o,
    output logic              pit_cs_n_o,
    output logic              ppi_cs_n_o,
    output logic              dma_page_cs_n_o,
    output logic              ems_sel_o,
    output logic              lpt_sel_o,
    output logic              io_cycle_o
);
    import xt_bus_pkg::*;

    logic       low_port_cycle;
    logic       port_cycle;
    logic [2:0] port_block;

    // Either strobe marks an I/O cycle
    assign io_cycle_o = ~io_read_n_i | ~io_write_n_i;

    // CPU owns the bus during this cycle
    assign port_cycle = io_cycle_o & ~address_enable_n_i;

    // First 256 ports only
    assign low_port_cycle = port_cycle & (address_i[9:8] == 2'b00);
    assign port_block     = address_i[7:5];

    assign dma_cs_n_o      = ~(low_port_cycle && (port_block == IO_PORT_DMA));
    assign pic_cs_n_o      = ~(low_port_cycle && (port_block == IO_PORT_PIC));
    assign pit_cs_n_o      = ~(low_port_cycle && (port_block == IO_PORT_PIT));
    assign ppi_cs_n_o      = ~(low_port_cycle && (port_block == IO_PORT_PPI));
    assign dma_page_cs_n_o = ~(low_port_cycle && (port_block == IO_PORT_DMA_PAGE));

    // EMS registers answer only when the board option is on
    assign ems_sel_o = port_cycle & ems_enabled_i & (address_i[15:2] == EMS_PORT_BASE);

    // 378h to 37Fh
    assign lpt_sel_o = port_cycle & (address_i[15:3] == LPT_PORT_BASE);

    // Low-port devices never share a bus cycle
    always_comb begin
        assert final ($onehot0({~dma_cs_n_o, ~pic_cs_n_o, ~pit_cs_n_o,
                                ~ppi_cs_n_o, ~dma_page_cs_n_o}))
        else $error("io_decoder: more than one low-port chip select active");
    end

endmodule

`default_nettype wire

// File: src/keyboard_port.sv
// Keyboard side-band port
// Syncs the keyboard interrupt and keycode from the external receiver,
// makes the keyboard reset request and the PS/2 clock inhibit

`default_nettype none

module keyboard_port (
    input  logic              clock,
    input  logic              reset,
    input  logic              kbd_irq_i,
    input  xt_bus_pkg::byte_t keycode_i,
    input  xt_bus_pkg::byte_t port_b_i,
    output logic              irq_o,
    output xt_bus_pkg::byte_t port_a_o,
    output logic              kbd_reset_req_o,
    output logic              ps2_clock_o
);
    import xt_bus_pkg::*;

    logic  irq_q;
    byte_t keycode_q;
    logic  port_b6_q;
    logic  port_b6_prev;

    // Two-stage pipelines toward the PIC and PPI port A
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            irq_q     <= 1'b0;
            irq_o     <= 1'b0;
            keycode_q <= '0;
            port_a_o  <= '0;
        end else begin
            irq_q     <= kbd_irq_i;
            irq_o     <= irq_q;
            keycode_q <= keycode_i;
            port_a_o  <= keycode_q;
        end
    end

    // Port B bit 6 releases the keyboard clock; its rise asks for a reset
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            port_b6_q       <= 1'b1;
            port_b6_prev    <= 1'b1;
            kbd_reset_req_o <= 1'b0;
            ps2_clock_o     <= 1'b1;
        end else begin
            port_b6_q       <= port_b_i[6];
            port_b6_prev    <= port_b6_q;
            kbd_reset_req_o <= port_b6_q & ~port_b6_prev;
            // Hold the clock low until the pending scancode is taken
            ps2_clock_o     <= ~(kbd_irq_i | ~port_b_i[6]);
        end
    end

    a_reset_req_pulse : assert property (@(posedge clock) disable iff (reset)
        kbd_reset_req_o |=> !kbd_reset_req_o)
        else $error("keyboard_port: reset request longer than one clock");

endmodule

`default_nettype wire

// File: src/timer_clock_divider.sv
// Timer clock divider
// Brings the peripheral clock into the bus clock domain and halves it
// to make the count clock of the timer

`default_nettype none

module timer_clock_divider (
    input  logic clock,
    input  logic reset,
    input  logic peripheral_clock_i,
    output logic timer_clock_o
);

    logic [1:0] sync_q;
    logic       sync_prev;
    logic       peripheral_rise;

    // Two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sync_q    <= 2'b00;
            sync_prev <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], peripheral_clock_i};
            sync_prev <= sync_q[1];
        end
    end

    assign peripheral_rise = sync_q[1] & ~sync_prev;

    // Toggle once per peripheral period
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            timer_clock_o <= 1'b0;
        end else if (peripheral_rise) begin
            timer_clock_o <= ~timer_clock_o;
        end
    end

endmodule

`default_nettype wire

// File: src/xt_bus_pkg.sv
// XT bus glue shared definitions
// Bus widths, I/O port addresses and EMS mapper constants

`default_nettype none

package xt_bus_pkg;

    // Bus widths
    typedef logic [19:0] addr_t;
    typedef logic [7:0]  byte_t;

    // EMS page number and register index
    typedef logic [6:0] ems_map_t;
    typedef logic [1:0] ems_slot_t;

    // Low port blocks, address bits 7 to 5
    localparam logic [2:0] IO_PORT_DMA      = 3'd0;
    localparam logic [2:0] IO_PORT_PIC      = 3'd1;
    localparam logic [2:0] IO_PORT_PIT      = 3'd2;
    localparam logic [2:0] IO_PORT_PPI      = 3'd3;
    localparam logic [2:0] IO_PORT_DMA_PAGE = 3'd4;

    // EMS registers 260h to 263h, compared on bits 15 to 2
    localparam logic [13:0] EMS_PORT_BASE = 14'h0098;

    // Parallel data port 378h, compared on bits 15 to 3
    localparam logic [12:0] LPT_PORT_BASE = 13'h006F;

    // Page frame nibbles
    localparam logic [3:0] EMS_FRAME_A = 4'hA;
    localparam logic [3:0] EMS_FRAME_C = 4'hC;
    localparam logic [3:0] EMS_FRAME_D = 4'hD;

    // EMS register write codes
    localparam byte_t EMS_DISABLE_CODE = 8'hFF;
    localparam byte_t EMS_MAP_LIMIT    = 8'h80;

    // Read value of an unmapped slot
    localparam byte_t IDLE_BYTE = 8'hFF;

    // EMS write FSM
    typedef enum logic {
        EMS_IDLE,
        EMS_COMMIT
    } ems_wr_state_t;

endpackage

`default_nettype wire

// File: src/xt_chipset_top.sv
// XT peripheral bus glue, top level
// Connects the decoder, EMS mapper, timer clock divider, keyboard port
// and read-back multiplexer; PIC, PIT and PPI sit outside

`default_nettype none

module xt_chipset_top (
    input  logic              clock,
    input  logic              reset,
    // CPU bus
    input  xt_bus_pkg::addr_t address_i,
    input  xt_bus_pkg::byte_t data_i,
    input  logic              io_read_n_i,
    input  logic              io_write_n_i,
    input  logic              memory_read_n_i,
    input  logic              address_enable_n_i,
    input  logic              inta_n_i,
    // External PIC, PIT and PPI
    input  xt_bus_pkg::byte_t pic_data_i,
    input  xt_bus_pkg::byte_t pit_data_i,
    input  xt_bus_pkg::byte_t ppi_data_i,
    output logic              dma_cs_n_o,
    output logic              pic_cs_n_o,
    output logic              pit_cs_n_o,
    output logic              ppi_cs_n_o,
    output logic              dma_page_cs_n_o,
    // Timer clock source
    input  logic              peripheral_clock_i,
    output logic              timer_clock_o,
    // Keyboard
    input  logic              kbd_irq_i,
    input  xt_bus_pkg::byte_t keycode_i,
    input  xt_bus_pkg::byte_t port_b_i,
    output xt_bus_pkg::byte_t port_a_o,
    output logic              irq_o,
    output logic              kbd_reset_req_o,
    output logic              ps2_clock_o,
    // EMS
    input  logic              ems_enabled_i,
    input  logic [1:0]        ems_frame_i,
    output logic [3:0]        ems_hit_o,
    // Read-back
    output xt_bus_pkg::byte_t data_bus_o,
    output logic              from_chipset_o
);
    import xt_bus_pkg::*;

    logic  ems_sel;
    logic  lpt_sel;
    logic  io_cycle;
    byte_t ems_read_byte;

    io_decoder u_io_decoder (
        .address_i          (address_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .address_enable_n_i (address_enable_n_i),
        .ems_enabled_i      (ems_enabled_i),
        .dma_cs_n_o         (dma_cs_n_o),
        .pic_cs_n_o         (pic_cs_n_o),
        .pit_cs_n_o         (pit_cs_n_o),
        .ppi_cs_n_o         (ppi_cs_n_o),
        .dma_page_cs_n_o    (dma_page_cs_n_o),
        .ems_sel_o          (ems_sel),
        .lpt_sel_o          (lpt_sel),
        .io_cycle_o         (io_cycle)
    );

    // A memory cycle is any cycle without an I/O strobe
    ems_mapper u_ems_mapper (
        .clock        (clock),
        .reset        (reset),
        .address_i    (address_i),
        .data_i       (data_i),
        .io_write_n_i (io_write_n_i),
        .ems_sel_i    (ems_sel),
        .io_cycle_i   (io_cycle),
        .ems_frame_i  (ems_frame_i),
        .ems_hit_o    (ems_hit_o),
        .read_byte_o  (ems_read_byte)
    );

    timer_clock_divider u_timer_clock_divider (
        .clock              (clock),
        .reset              (reset),
        .peripheral_clock_i (peripheral_clock_i),
        .timer_clock_o      (timer_clock_o)
    );

    keyboard_port u_keyboard_port (
        .clock           (clock),
        .reset           (reset),
        .kbd_irq_i       (kbd_irq_i),
        .keycode_i       (keycode_i),
        .port_b_i        (port_b_i),
        .irq_o           (irq_o),
        .port_a_o        (port_a_o),
        .kbd_reset_req_o (kbd_reset_req_o),
        .ps2_clock_o     (ps2_clock_o)
    );

    bus_read_mux u_bus_read_mux (
        .clock          (clock),
        .reset          (reset),
        .data_i         (data_i),
        .io_read_n_i    (io_read_n_i),
        .io_write_n_i   (io_write_n_i),
        .inta_n_i       (inta_n_i),
        .pic_cs_n_i     (pic_cs_n_o),
        .pit_cs_n_i     (pit_cs_n_o),
        .ppi_cs_n_i     (ppi_cs_n_o),
        .ems_sel_i      (ems_sel),
        .lpt_sel_i      (lpt_sel),
        .pic_data_i     (pic_data_i),
        .pit_data_i     (pit_data_i),
        .ppi_data_i     (ppi_data_i),
        .ems_data_i     (ems_read_byte),
        .data_bus_o     (data_bus_o),
        .from_chipset_o (from_chipset_o)
    );

endmodule

`default_nettype wire

// File: vlog.f
src/xt_bus_pkg.sv
src/io_decoder.sv
src/ems_mapper.sv
src/timer_clock_divider.sv
src/keyboard_port.sv
src/bus_read_mux.sv
src/xt_chipset_top.sv
bench/tb_xt_chipset.sv
